// ==== filelist.f ====
+incdir+bench
logic/riscvPkg.sv
logic/controlUnit.sv
logic/immExtender.sv
logic/registerFile.sv
logic/hazardUnit.sv
logic/decodeStage.sv
logic/decodeTop.sv
bench/decodeTb.sv

// ==== Bender.yml ====
package:
  name: riscv_decode

sources:
  - files:
      - logic/riscvPkg.sv
      - logic/controlUnit.sv
      - logic/immExtender.sv
      - logic/registerFile.sv
      - logic/hazardUnit.sv
      - logic/decodeStage.sv
      - logic/decodeTop.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/decodeTb.sv

// ==== bench/decodeRef.svh ====
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// execute-side control group, packed in the same order as the DUT outputs
typedef struct packed {
   logic regWrite;
   logic memWrite;
   logic jump;
   logic branch;
   logic aluSrc;
   logic [1:0] resultSrc;
   logic [2:0] aluControl;
   logic byteAddress;
   logic readEnable;
} ctrlBits;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one LFSR step per bit taken
function automatic logic [31:0] takeBits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
   end
   return v;
endfunction

function automatic ctrlBits refControl(input logic [6:0] op, input logic [2:0] f3,
                                       input logic b5);
   ctrlBits c;
   logic memOp;
   logic aluOp;
   c = '0;
   memOp = (op == opLoad) || (op == opStore);
   aluOp = (op == opRType) || (op == opIType);
   c.regWrite = (op == opLoad) || aluOp || (op == opJal);
   c.memWrite = (op == opStore);
   c.jump = (op == opJal);
   c.branch = (op == opBranch);
   c.aluSrc = memOp || (op == opIType);
   c.readEnable = (op == opLoad);
   // lb and sb
   c.byteAddress = memOp && (f3 == 3'b000);
   if (op == opLoad) begin
      c.resultSrc = resultMem;
   end else if (op == opJal) begin
      c.resultSrc = resultPc4;
   end
   if (op == opBranch) begin
      c.aluControl = aluSub;
   end else if (aluOp) begin
      case (f3)
         3'b000: c.aluControl = (op == opRType && b5) ? aluSub : aluAdd;
         3'b001: c.aluControl = aluSll;
         3'b010: c.aluControl = aluSlt;
         3'b100: c.aluControl = aluXor;
         3'b101: c.aluControl = aluSrl;
         3'b110: c.aluControl = aluOr;
         3'b111: c.aluControl = aluAnd;
         default: c.aluControl = aluAdd;
      endcase
   end
   return c;
endfunction

// format follows the opcode, I format for everything else
function automatic logic [wordSize-1:0] refImm(input logic [wordSize-1:0] i);
   case (i[6:0])
      opStore: return {{20{i[31]}}, i[31:25], i[11:7]};
      opBranch: return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
      opJal: return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
      default: return {{20{i[31]}}, i[31:20]};
   endcase
endfunction

`endif

// ==== bench/decodeTb.sv ====
`timescale 1ns/100ps

module decodeTb;
   import riscvPkg::*;

   localparam int numWrites = 40;
   localparam int numDecodes = 200;
   // reset, hazard and flush sequences, two tail cycles per test
   localparam int stimCycles = 4 + numWrites + numDecodes + 10 + 8 + 5 * 2;
   localparam int cycleLimit = stimCycles * 2 + 50;
   localparam logic [wordSize-1:0] nop = '0;

   logic clk = 1'b0;
   logic rst;
   logic [wordSize-1:0] instrD, pcD, pcPlus4D, resultW;
   logic regWriteW, takenBranchE, holdE;
   logic [regAddrBits-1:0] rdW;
   logic [wordSize-1:0] rd1E, rd2E, pcE, pcPlus4E, immExtE;
   logic [regAddrBits-1:0] rs1E, rs2E, rdE, rs1D, rs2D;
   logic regWriteE, memWriteE, jumpE, branchE, aluSrcE, byteAddressE, readEnableE;
   logic [1:0] resultSrcE;
   logic [2:0] aluControlE;
   logic stallD;
   logic [31:0] lfsrState = 32'hf189959c;

   `include "decodeRef.svh"

   typedef struct packed {
      logic [wordSize-1:0] rd1;
      logic [wordSize-1:0] rd2;
      logic [wordSize-1:0] pc;
      logic [wordSize-1:0] pcPlus4;
      logic [wordSize-1:0] imm;
      logic [regAddrBits-1:0] rs1;
      logic [regAddrBits-1:0] rs2;
      logic [regAddrBits-1:0] rd;
      ctrlBits ctrl;
   } stageE;

   // what the DUT shows at the negedge after a step
   typedef struct packed {
      stageE e;
      logic [regAddrBits-1:0] rs1D;
      logic [regAddrBits-1:0] rs2D;
      logic stall;
   } expEntry;

   stageE modelE;
   expEntry expQ[$];
   logic [wordSize-1:0] shadow [0:31];
   int errors = 0;
   int checks = 0;
   int cycles = 0;
   int tests = 0;
   int errorsAtStart = 0;
   int checksAtStart = 0;

   decodeTop DUT (.*);

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycleLimit) begin
         $display("timeout: run still going after %0d cycles", cycleLimit);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   task automatic checkWord(input string name, input logic [wordSize-1:0] got,
                            input logic [wordSize-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic checkReg(input string name, input logic [regAddrBits-1:0] got,
                           input logic [regAddrBits-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic checkCtrl(input string name, input ctrlBits got, input ctrlBits exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   always @(negedge clk) begin : compare
      expEntry x;
      if (expQ.size() > 0) begin
         x = expQ.pop_front();
         checkWord("rd1E", rd1E, x.e.rd1);
         checkWord("rd2E", rd2E, x.e.rd2);
         checkWord("pcE", pcE, x.e.pc);
         checkWord("pcPlus4E", pcPlus4E, x.e.pcPlus4);
         checkWord("immExtE", immExtE, x.e.imm);
         checkReg("rs1E", rs1E, x.e.rs1);
         checkReg("rs2E", rs2E, x.e.rs2);
         checkReg("rdE", rdE, x.e.rd);
         checkCtrl("controlE", {regWriteE, memWriteE, jumpE, branchE, aluSrcE, resultSrcE,
                                aluControlE, byteAddressE, readEnableE}, x.e.ctrl);
         checkReg("rs1D", rs1D, x.rs1D);
         checkReg("rs2D", rs2D, x.rs2D);
         checkFlag("stallD", stallD, x.stall);
      end
   end

   // x0 is zero, a write in the same cycle is seen at once
   function automatic logic [wordSize-1:0] readShadow(input logic [regAddrBits-1:0] a,
         input logic wbEn, input logic [regAddrBits-1:0] wbRd,
         input logic [wordSize-1:0] wbData);
      if (a == '0) begin
         return '0;
      end else if (wbEn && a == wbRd) begin
         return wbData;
      end
      return shadow[a];
   endfunction

   // one fetch cycle, plus the model of the execute register
   task automatic step(input logic [wordSize-1:0] instr, input logic [wordSize-1:0] pc,
         input logic wbEn, input logic [regAddrBits-1:0] wbRd,
         input logic [wordSize-1:0] wbData, input logic branch, input logic hold);
      stageE nextE;
      expEntry x;
      logic stall;
      @(posedge clk);
      instrD <= instr;
      pcD <= pc;
      pcPlus4D <= pc + 4;
      regWriteW <= wbEn;
      rdW <= wbRd;
      resultW <= wbData;
      takenBranchE <= branch;
      holdE <= hold;
      // load in execute feeding either source field in decode
      stall = (modelE.ctrl.resultSrc == resultMem) && (modelE.rd != '0) &&
              (modelE.rd == instr[19:15] || modelE.rd == instr[24:20]);
      x.e = modelE;
      x.rs1D = instr[19:15];
      x.rs2D = instr[24:20];
      x.stall = stall;
      expQ.push_back(x);
      nextE.rd1 = readShadow(instr[19:15], wbEn, wbRd, wbData);
      nextE.rd2 = readShadow(instr[24:20], wbEn, wbRd, wbData);
      nextE.pc = pc;
      nextE.pcPlus4 = pc + 4;
      nextE.imm = refImm(instr);
      nextE.rs1 = instr[19:15];
      nextE.rs2 = instr[24:20];
      nextE.rd = instr[11:7];
      nextE.ctrl = refControl(instr[6:0], instr[14:12], instr[30]);
      if (stall || branch) begin
         modelE = '0;
      end else if (!hold) begin
         modelE = nextE;
      end
      if (wbEn && wbRd != '0) begin
         shadow[wbRd] = wbData;
      end
   endtask

   task automatic endTest(input string name);
      step(nop, '0, 1'b0, '0, '0, 1'b0, 1'b0);
      @(posedge clk);
      tests++;
      $display("test %s: %0d checks, %0d errors", name, checks - checksAtStart,
               errors - errorsAtStart);
      checksAtStart = checks;
      errorsAtStart = errors;
   endtask

   function automatic logic [wordSize-1:0] randomInstr();
      logic [2:0] kind;
      logic [2:0] f3;
      logic [2:0] memF3;
      logic [4:0] rd, rs1, rs2;
      logic [11:0] imm;
      logic [19:0] upper;
      kind = 3'(takeBits(3));
      rd = 5'(takeBits(5));
      rs1 = 5'(takeBits(5));
      rs2 = 5'(takeBits(5));
      imm = 12'(takeBits(12));
      upper = 20'(takeBits(20));
      f3 = 3'(takeBits(3));
      // sltu is not supported
      if (f3 == 3'b011) begin
         f3 = 3'b000;
      end
      memF3 = takeBits(1) != 0 ? 3'b000 : 3'b010;
      case (kind)
         3'd0: return {imm, rs1, memF3, rd, opLoad};
         3'd1: return {imm[11:5], rs2, rs1, memF3, imm[4:0], opStore};
         3'd2, 3'd7: return {(f3 == 3'b000 && imm[0]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, opRType};
         3'd3: begin
            // shift amounts keep the top seven bits clear
            if (f3 == 3'b001 || f3 == 3'b101) begin
               imm[11:5] = '0;
            end
            return {imm, rs1, f3, rd, opIType};
         end
         3'd4: return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], opBranch};
         3'd5: return {upper, rd, opJal};
         // lui, outside the decoded set
         default: return {upper, rd, 7'b0110111};
      endcase
   endfunction

   initial begin : stimulus
      expEntry resetEntry;
      logic [wordSize-1:0] load, user, other;
      logic [regAddrBits-1:0] r, wr, rs;
      rst = 1'b1;
      instrD = '0;
      pcD = '0;
      pcPlus4D = '0;
      resultW = '0;
      regWriteW = 1'b0;
      rdW = '0;
      takenBranchE = 1'b0;
      holdE = 1'b0;
      modelE = '0;
      for (int i = 0; i < 32; i++) begin
         shadow[i] = '0;
      end
      repeat (3) @(posedge clk);
      resetEntry = '0;
      expQ.push_back(resetEntry);
      @(posedge clk);
      rst <= 1'b0;
      endTest("reset");

      // rs2 always reads the register written in that cycle
      for (int i = 0; i < numWrites; i++) begin
         wr = (i % 8 == 0) ? 5'd0 : 5'(takeBits(5));
         rs = (i % 8 == 4) ? 5'd0 : 5'(takeBits(5));
         step({7'h00, wr, rs, 3'b000, 5'd1, opRType}, takeBits(30) << 2, 1'b1, wr,
              takeBits(32), 1'b0, 1'b0);
      end
      endTest("regfile");

      for (int i = 0; i < numDecodes; i++) begin
         user = randomInstr();
         wr = 5'(takeBits(5));
         step(user, takeBits(30) << 2, takeBits(1) != 0, wr, takeBits(32), 1'b0, 1'b0);
      end
      endTest("decode");

      r = 5'(takeBits(4)) + 5'd1;
      load = {12'h010, 5'd2, 3'b010, r, opLoad};
      user = {7'h00, 5'd3, r, 3'b000, 5'd4, opRType};
      step(load, 32'h100, 1'b0, '0, '0, 1'b0, 1'b0);
      step(user, 32'h104, 1'b0, '0, '0, 1'b0, 1'b0);
      // fetch holds the same word while stalled
      step(user, 32'h104, 1'b0, '0, '0, 1'b0, 1'b0);
      other = {7'h00, r, 5'd5, 3'b010, 5'd6, opStore};
      step(load, 32'h108, 1'b0, '0, '0, 1'b0, 1'b0);
      step(other, 32'h10c, 1'b0, '0, '0, 1'b0, 1'b0);
      step(other, 32'h10c, 1'b0, '0, '0, 1'b0, 1'b0);
      step({12'h000, 5'd2, 3'b010, 5'd0, opLoad}, 32'h110, 1'b0, '0, '0, 1'b0, 1'b0);
      step({7'h00, 5'd0, 5'd0, 3'b000, 5'd7, opRType}, 32'h114, 1'b0, '0, '0, 1'b0, 1'b0);
      step(load, 32'h118, 1'b0, '0, '0, 1'b0, 1'b0);
      step({7'h00, r + 5'd2, r + 5'd1, 3'b000, 5'd8, opRType}, 32'h11c, 1'b0, '0, '0,
           1'b0, 1'b0);
      endTest("hazard");

      load = {7'h00, 5'd9, 5'd10, 3'b110, 5'd11, opRType};
      user = {12'h7f3, 5'd12, 3'b100, 5'd13, opIType};
      other = {7'h20, 5'd14, 5'd15, 3'b000, 5'd16, opRType};
      step(load, 32'h200, 1'b0, '0, '0, 1'b0, 1'b0);
      step(user, 32'h204, 1'b0, '0, '0, 1'b1, 1'b0);
      step(other, 32'h208, 1'b0, '0, '0, 1'b0, 1'b0);
      step(user, 32'h20c, 1'b0, '0, '0, 1'b0, 1'b1);
      step(load, 32'h210, 1'b0, '0, '0, 1'b0, 1'b1);
      step(other, 32'h214, 1'b0, '0, '0, 1'b0, 1'b0);
      step(user, 32'h218, 1'b0, '0, '0, 1'b1, 1'b1);
      step(load, 32'h21c, 1'b0, '0, '0, 1'b0, 1'b0);
      endTest("flushHold");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== logic/decodeTop.sv ====
`timescale 1ns/100ps

module decodeTop (
   input logic clk,
   input logic rst,
   input logic [riscvPkg::wordSize-1:0] instrD,
   input logic [riscvPkg::wordSize-1:0] pcD,
   input logic [riscvPkg::wordSize-1:0] pcPlus4D,
   input logic [riscvPkg::wordSize-1:0] resultW,
   input logic regWriteW,
   input logic [riscvPkg::regAddrBits-1:0] rdW,
   input logic takenBranchE,
   input logic holdE,
   output logic [riscvPkg::wordSize-1:0] rd1E,
   output logic [riscvPkg::wordSize-1:0] rd2E,
   output logic [riscvPkg::wordSize-1:0] pcE,
   output logic [riscvPkg::wordSize-1:0] pcPlus4E,
   output logic [riscvPkg::wordSize-1:0] immExtE,
   output logic [riscvPkg::regAddrBits-1:0] rs1E,
   output logic [riscvPkg::regAddrBits-1:0] rs2E,
   output logic [riscvPkg::regAddrBits-1:0] rdE,
   output logic regWriteE,
   output logic memWriteE,
   output logic jumpE,
   output logic branchE,
   output logic aluSrcE,
   output logic [1:0] resultSrcE,
   output logic [2:0] aluControlE,
   output logic byteAddressE,
   output logic readEnableE,
   output logic stallD,
   output logic [riscvPkg::regAddrBits-1:0] rs1D,
   output logic [riscvPkg::regAddrBits-1:0] rs2D
);

   // hazard decision back into the execute register
   logic flushE;

   decodeStage decode (
      .clk(clk),
      .rst(rst),
      .instrD(instrD),
      .pcD(pcD),
      .pcPlus4D(pcPlus4D),
      .resultW(resultW),
      .regWriteW(regWriteW),
      .rdW(rdW),
      .flushE(flushE),
      .holdE(holdE),
      .rd1E(rd1E),
      .rd2E(rd2E),
      .pcE(pcE),
      .pcPlus4E(pcPlus4E),
      .immExtE(immExtE),
      .rs1E(rs1E),
      .rs2E(rs2E),
      .rdE(rdE),
      .regWriteE(regWriteE),
      .memWriteE(memWriteE),
      .jumpE(jumpE),
      .branchE(branchE),
      .aluSrcE(aluSrcE),
      .resultSrcE(resultSrcE),
      .aluControlE(aluControlE),
      .byteAddressE(byteAddressE),
      .readEnableE(readEnableE),
      .rs1D(rs1D),
      .rs2D(rs2D)
   );

   hazardUnit hazard (
      .rs1D(rs1D),
      .rs2D(rs2D),
      .rdE(rdE),
      .resultSrcE(resultSrcE),
      .takenBranchE(takenBranchE),
      .stallD(stallD),
      .flushE(flushE)
   );

endmodule

// ==== logic/decodeStage.sv ====
`timescale 1ns/100ps

module decodeStage (
   input logic clk,
   input logic rst,
   input riscvPkg::instrWord instrD,
   input logic [riscvPkg::wordSize-1:0] pcD,
   input logic [riscvPkg::wordSize-1:0] pcPlus4D,
   input logic [riscvPkg::wordSize-1:0] resultW,
   input logic regWriteW,
   input logic [riscvPkg::regAddrBits-1:0] rdW,
   input logic flushE,
   input logic holdE,
   output logic [riscvPkg::wordSize-1:0] rd1E,
   output logic [riscvPkg::wordSize-1:0] rd2E,
   output logic [riscvPkg::wordSize-1:0] pcE,
   output logic [riscvPkg::wordSize-1:0] pcPlus4E,
   output logic [riscvPkg::wordSize-1:0] immExtE,
   output logic [riscvPkg::regAddrBits-1:0] rs1E,
   output logic [riscvPkg::regAddrBits-1:0] rs2E,
   output logic [riscvPkg::regAddrBits-1:0] rdE,
   output logic regWriteE,
   output logic memWriteE,
   output logic jumpE,
   output logic branchE,
   output logic aluSrcE,
   output logic [1:0] resultSrcE,
   output logic [2:0] aluControlE,
   output logic byteAddressE,
   output logic readEnableE,
   output logic [riscvPkg::regAddrBits-1:0] rs1D,
   output logic [riscvPkg::regAddrBits-1:0] rs2D
);
   import riscvPkg::*;

   logic [wordSize-1:0] rd1D, rd2D, immExtD;
   logic regWriteD, memWriteD, jumpD, branchD, aluSrcD;
   logic byteAddressD, readEnableD;
   logic [1:0] resultSrcD, immSrcD;
   logic [2:0] aluControlD;

   // source numbers, also used by forwarding outside
   assign rs1D = instrD.rType.rs1;
   assign rs2D = instrD.rType.rs2;

   registerFile regFile (
      .clk(clk),
      .rst(rst),
      .addr1(instrD.rType.rs1),
      .addr2(instrD.rType.rs2),
      .addr3(rdW),
      .writeEnable(regWriteW),
      .writeData(resultW),
      .readData1(rd1D),
      .readData2(rd2D)
   );

   controlUnit ctrl (
      .op(instrD.rType.opcode),
      .funct3(instrD.rType.funct3),
      .funct7b5(instrD.rType.funct7[5]),
      .regWrite(regWriteD),
      .resultSrc(resultSrcD),
      .memWrite(memWriteD),
      .jump(jumpD),
      .branch(branchD),
      .aluControl(aluControlD),
      .aluSrc(aluSrcD),
      .immSrc(immSrcD),
      .byteAddress(byteAddressD),
      .readEnable(readEnableD)
   );

   immExtender ext (
      .instr(instrD),
      .immSrc(immSrcD),
      .immExt(immExtD)
   );

   // decode to execute register, flush beats hold
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         {rd1E, rd2E, pcE, pcPlus4E, immExtE, rs1E, rs2E, rdE} <= '0;
         {regWriteE, memWriteE, jumpE, branchE, aluSrcE} <= '0;
         {resultSrcE, aluControlE, byteAddressE, readEnableE} <= '0;
      end else if (flushE) begin
         // bubble, all controls inactive
         {rd1E, rd2E, pcE, pcPlus4E, immExtE, rs1E, rs2E, rdE} <= '0;
         {regWriteE, memWriteE, jumpE, branchE, aluSrcE} <= '0;
         {resultSrcE, aluControlE, byteAddressE, readEnableE} <= '0;
      end else if (!holdE) begin
         {rd1E, rd2E, pcE, pcPlus4E, immExtE} <= {rd1D, rd2D, pcD, pcPlus4D, immExtD};
         {rs1E, rs2E, rdE} <= {instrD.rType.rs1, instrD.rType.rs2, instrD.rType.rd};
         {regWriteE, memWriteE, jumpE, branchE, aluSrcE} <=
            {regWriteD, memWriteD, jumpD, branchD, aluSrcD};
         {resultSrcE, aluControlE, byteAddressE, readEnableE} <=
            {resultSrcD, aluControlD, byteAddressD, readEnableD};
      end
   end

endmodule

// ==== logic/hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit (
   input logic [riscvPkg::regAddrBits-1:0] rs1D,
   input logic [riscvPkg::regAddrBits-1:0] rs2D,
   input logic [riscvPkg::regAddrBits-1:0] rdE,
   input logic [1:0] resultSrcE,
   input logic takenBranchE,
   output logic stallD,
   output logic flushE
);
   import riscvPkg::*;

   logic loadInE;
   logic srcMatch;

   // the instruction in execute reads memory
   assign loadInE = (resultSrcE == resultMem);

   // x0 never creates a dependency
   assign srcMatch = (rdE != '0) && ((rdE == rs1D) || (rdE == rs2D));

   // load-use, hold decode one cycle
   assign stallD = loadInE && srcMatch;

   // bubble into execute on a stall or a redirect
   assign flushE = stallD || takenBranchE;

endmodule

// ==== logic/registerFile.sv ====
`timescale 1ns/100ps

module registerFile (
   input logic clk,
   input logic rst,
   input logic [riscvPkg::regAddrBits-1:0] addr1,
   input logic [riscvPkg::regAddrBits-1:0] addr2,
   input logic [riscvPkg::regAddrBits-1:0] addr3,
   input logic writeEnable,
   input logic [riscvPkg::wordSize-1:0] writeData,
   output logic [riscvPkg::wordSize-1:0] readData1,
   output logic [riscvPkg::wordSize-1:0] readData2
);
   import riscvPkg::*;

   // x0 has no storage
   logic [wordSize-1:0] regs [1:31];
   logic writeHit;

   assign writeHit = writeEnable && (addr3 != '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (writeHit) begin
         regs[addr3] <= writeData;
      end
   end

   // zero for x0, bypass when the same register is written this cycle
   function automatic logic [wordSize-1:0] readPort(input logic [regAddrBits-1:0] addr);
      if (addr == '0) begin
         return '0;
      end else if (writeHit && (addr == addr3)) begin
         return writeData;
      end
      return regs[addr];
   endfunction

   always_comb readData1 = readPort(addr1);
   always_comb readData2 = readPort(addr2);

endmodule

// ==== logic/immExtender.sv ====
`timescale 1ns/100ps

module immExtender (
   input riscvPkg::instrWord instr,
   input logic [1:0] immSrc,
   output logic [riscvPkg::wordSize-1:0] immExt
);
   import riscvPkg::*;

   always_comb begin
      case (immSrc)
         immI: begin
            immExt = {{20{instr.iType.imm[11]}}, instr.iType.imm};
         end
         immS: begin
            immExt = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
         end
         immB: begin
            immExt = {{20{instr.bType.imm12}}, instr.bType.imm11, instr.bType.immHi,
                      instr.bType.immLo, 1'b0};
         end
         default: begin
            // J format, imm[19:12] sits where rs1 and funct3 are
            immExt = {{12{instr.iType.imm[11]}}, instr.iType.rs1, instr.iType.funct3,
                      instr.iType.imm[0], instr.iType.imm[10:1], 1'b0};
         end
      endcase
   end

endmodule

// ==== logic/controlUnit.sv ====
`timescale 1ns/100ps

module controlUnit (
   input logic [6:0] op,
   input logic [2:0] funct3,
   input logic funct7b5,
   output logic regWrite,
   output logic [1:0] resultSrc,
   output logic memWrite,
   output logic jump,
   output logic branch,
   output logic [2:0] aluControl,
   output logic aluSrc,
   output logic [1:0] immSrc,
   output logic byteAddress,
   output logic readEnable
);
   import riscvPkg::*;

   // set for R-type and I-type ALU ops
   logic functOp;

   // main decoder, unknown opcodes fall through to all zeros
   always_comb begin
      regWrite = 1'b0;
      resultSrc = resultAlu;
      memWrite = 1'b0;
      jump = 1'b0;
      branch = 1'b0;
      aluSrc = 1'b0;
      immSrc = immI;
      readEnable = 1'b0;
      functOp = 1'b0;
      case (op)
         opLoad: begin
            regWrite = 1'b1;
            resultSrc = resultMem;
            aluSrc = 1'b1;
            readEnable = 1'b1;
         end
         opStore: begin
            memWrite = 1'b1;
            aluSrc = 1'b1;
            immSrc = immS;
         end
         opRType: begin
            regWrite = 1'b1;
            functOp = 1'b1;
         end
         opIType: begin
            regWrite = 1'b1;
            aluSrc = 1'b1;
            functOp = 1'b1;
         end
         opBranch: begin
            branch = 1'b1;
            immSrc = immB;
         end
         opJal: begin
            regWrite = 1'b1;
            resultSrc = resultPc4;
            jump = 1'b1;
            immSrc = immJ;
         end
         default: ;
      endcase
   end

   // lb and sb only
   assign byteAddress = ((op == opLoad) || (op == opStore)) && (funct3 == f3Byte);

   // ALU decoder
   always_comb begin
      aluControl = aluAdd;
      if (branch) begin
         // beq compares by subtraction
         aluControl = aluSub;
      end else if (functOp) begin
         case (funct3)
            f3AddSub: aluControl = ((op == opRType) && funct7b5) ? aluSub : aluAdd;
            f3Sll: aluControl = aluSll;
            f3Slt: aluControl = aluSlt;
            f3Xor: aluControl = aluXor;
            f3Srl: aluControl = aluSrl;
            f3Or: aluControl = aluOr;
            f3And: aluControl = aluAnd;
            default: aluControl = aluAdd;
         endcase
      end
   end

endmodule

// ==== logic/riscvPkg.sv ====
package riscvPkg;

   localparam int wordSize = 32;
   localparam int regAddrBits = 5;

   // major opcodes
   localparam logic [6:0] opLoad = 7'b0000011;
   localparam logic [6:0] opStore = 7'b0100011;
   localparam logic [6:0] opRType = 7'b0110011;
   localparam logic [6:0] opIType = 7'b0010011;
   localparam logic [6:0] opBranch = 7'b1100011;
   localparam logic [6:0] opJal = 7'b1101111;

   // funct3 values for the ALU group
   localparam logic [2:0] f3AddSub = 3'b000;
   localparam logic [2:0] f3Sll = 3'b001;
   localparam logic [2:0] f3Slt = 3'b010;
   localparam logic [2:0] f3Xor = 3'b100;
   localparam logic [2:0] f3Srl = 3'b101;
   localparam logic [2:0] f3Or = 3'b110;
   localparam logic [2:0] f3And = 3'b111;
   // lb and sb share this funct3
   localparam logic [2:0] f3Byte = 3'b000;

   // ALU control for execute
   localparam logic [2:0] aluAdd = 3'b000;
   localparam logic [2:0] aluSub = 3'b001;
   localparam logic [2:0] aluAnd = 3'b010;
   localparam logic [2:0] aluOr = 3'b011;
   localparam logic [2:0] aluXor = 3'b100;
   localparam logic [2:0] aluSlt = 3'b101;
   localparam logic [2:0] aluSll = 3'b110;
   localparam logic [2:0] aluSrl = 3'b111;

   // result source in write-back
   localparam logic [1:0] resultAlu = 2'b00;
   localparam logic [1:0] resultMem = 2'b01;
   localparam logic [1:0] resultPc4 = 2'b10;

   // immediate format select
   localparam logic [1:0] immI = 2'b00;
   localparam logic [1:0] immS = 2'b01;
   localparam logic [1:0] immB = 2'b10;
   localparam logic [1:0] immJ = 2'b11;

   typedef struct packed {
      logic [6:0] funct7;
      logic [regAddrBits-1:0] rs2;
      logic [regAddrBits-1:0] rs1;
      logic [2:0] funct3;
      logic [regAddrBits-1:0] rd;
      logic [6:0] opcode;
   } rTypeFields;

   typedef struct packed {
      logic [11:0] imm;
      logic [regAddrBits-1:0] rs1;
      logic [2:0] funct3;
      logic [regAddrBits-1:0] rd;
      logic [6:0] opcode;
   } iTypeFields;

   typedef struct packed {
      logic [6:0] immHi;
      logic [regAddrBits-1:0] rs2;
      logic [regAddrBits-1:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sTypeFields;

   typedef struct packed {
      logic imm12;
      logic [5:0] immHi;
      logic [regAddrBits-1:0] rs2;
      logic [regAddrBits-1:0] rs1;
      logic [2:0] funct3;
      logic [3:0] immLo;
      logic imm11;
      logic [6:0] opcode;
   } bTypeFields;

   // one fetched word, seen through each format
   typedef union packed {
      rTypeFields rType;
      iTypeFields iType;
      sTypeFields sType;
      bTypeFields bType;
   } instrWord;

endpackage
